// File: Makefile
TOP = id_stage_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f id_stage.f --top-module id_stage
	verilator --lint-only --timing -f id_stage.f --top-module $(TOP)

sim:
	verilator --binary --timing -f id_stage.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

// File: id_bypass.sv
`timescale 1ns/1ns

module id_bypass
  import rv_isa_pkg::*;
(
  input  reg_idx_t rs1_idx_i,
  input  reg_idx_t rs2_idx_i,
  input  xlen_t    rs1_rdata_i,
  input  xlen_t    rs2_rdata_i,
  input  reg_idx_t ex_rd_idx_i,
  input  xlen_t    ex_rd_data_i,
  input  reg_idx_t mem_rd_idx_i,
  input  xlen_t    mem_rd_data_i,
  output xlen_t    rs1_data_o,
  output xlen_t    rs2_data_o,
  output logic     ex_hit_o
);

  logic rs1_ex_hit;
  logic rs2_ex_hit;
  logic rs1_mem_hit;
  logic rs2_mem_hit;

  // x0 is hardwired, never forward into it
  function automatic logic idx_match(input reg_idx_t src, input reg_idx_t dst);
    return (src != '0) && (src == dst);
  endfunction

  assign rs1_ex_hit  = idx_match(rs1_idx_i, ex_rd_idx_i);
  assign rs2_ex_hit  = idx_match(rs2_idx_i, ex_rd_idx_i);
  assign rs1_mem_hit = idx_match(rs1_idx_i, mem_rd_idx_i);
  assign rs2_mem_hit = idx_match(rs2_idx_i, mem_rd_idx_i);

  // priority ex > mem > register file
  assign rs1_data_o = rs1_ex_hit  ? ex_rd_data_i  :
                      rs1_mem_hit ? mem_rd_data_i :
                      rs1_rdata_i;
  assign rs2_data_o = rs2_ex_hit  ? ex_rd_data_i  :
                      rs2_mem_hit ? mem_rd_data_i :
                      rs2_rdata_i;

  // used for load-use detection
  assign ex_hit_o = rs1_ex_hit | rs2_ex_hit;

endmodule

// File: id_ctrl.sv
`timescale 1ns/1ns

module id_ctrl
  import rv_isa_pkg::*;
  import id_uop_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  logic     out_ready_i,
  output logic     out_valid_o,
  input  exc_op_e  ex_exc_op_i,
  input  logic     ex_hit_i,
  input  xlen_t    in_pc_i,
  input  reg_idx_t rs1_idx_i,
  input  reg_idx_t rs2_idx_i,
  input  reg_idx_t rd_idx_i,
  input  xlen_t    rs1_data_i,
  input  xlen_t    rs2_data_i,
  input  xlen_t    imm_i,
  input  alu_op_e  alu_op_i,
  input  mem_op_e  mem_op_i,
  input  exc_op_e  exc_op_i,
  input  pc_op_e   pc_op_i,
  output xlen_t    out_pc_o,
  output reg_idx_t out_rs1_idx_o,
  output reg_idx_t out_rs2_idx_o,
  output reg_idx_t out_rd_idx_o,
  output xlen_t    out_rs1_data_o,
  output xlen_t    out_rs2_data_o,
  output xlen_t    out_imm_o,
  output alu_op_e  out_alu_op_o,
  output mem_op_e  out_mem_op_o,
  output exc_op_e  out_exc_op_o,
  output pc_op_e   out_pc_op_o
);

  logic load_use;
  logic accept;

  // load data is not ready yet for a dependent instruction
  assign load_use = (ex_exc_op_i == EXC_LOAD) && ex_hit_i;

  assign in_ready_o = (!out_valid_o || out_ready_i) && !load_use;
  assign accept     = in_valid_i && in_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_o <= 1'b0;
    end else if (accept) begin
      out_valid_o <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_o <= 1'b0;
    end
  end

  // payload only moves on acceptance, so it holds under back-pressure
  always_ff @(posedge clk_i) begin
    if (accept) begin
      out_pc_o       <= in_pc_i;
      out_rs1_idx_o  <= rs1_idx_i;
      out_rs2_idx_o  <= rs2_idx_i;
      out_rd_idx_o   <= rd_idx_i;
      out_rs1_data_o <= rs1_data_i;
      out_rs2_data_o <= rs2_data_i;
      out_imm_o      <= imm_i;
      out_alu_op_o   <= alu_op_i;
      out_mem_op_o   <= mem_op_i;
      out_exc_op_o   <= exc_op_i;
      out_pc_op_o    <= pc_op_i;
    end
  end

endmodule

// File: id_imm_gen.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module id_imm_gen
  import rv_isa_pkg::*;
  import id_uop_pkg::*;
(
  input  inst_t    inst_i,
  input  imm_fmt_e fmt_i,
  output xlen_t    imm_o
);

  logic sgn;

  // all formats keep the sign in bit 31
  assign sgn = inst_i[31];

  always_comb begin
    case (fmt_i)
      IMM_I: begin
        imm_o = {{(`RV_IMM_W-11){sgn}}, inst_i[30:20]};
      end
      IMM_S: begin
        imm_o = {{(`RV_IMM_W-11){sgn}}, inst_i[30:25], inst_i[11:7]};
      end
      // branch offset, halfword aligned
      IMM_B: begin
        imm_o = {{(`RV_IMM_W-12){sgn}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
      end
      // upper 20 bits, low 12 cleared
      IMM_U: begin
        imm_o = {{(`RV_IMM_W-31){sgn}}, inst_i[30:12], 12'b0};
      end
      IMM_J: begin
        imm_o = {{(`RV_IMM_W-20){sgn}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
      end
      default: begin
        imm_o = '0;
      end
    endcase
  end

endmodule

// File: id_inst_dec.sv
`timescale 1ns/1ns

module id_inst_dec
  import rv_isa_pkg::*;
  import id_uop_pkg::*;
(
  input  inst_t    inst_i,
  output reg_idx_t rs1_idx_o,
  output reg_idx_t rs2_idx_o,
  output reg_idx_t rd_idx_o,
  output alu_op_e  alu_op_o,
  output mem_op_e  mem_op_o,
  output exc_op_e  exc_op_o,
  output pc_op_e   pc_op_o,
  output imm_fmt_e imm_fmt_o
);

  opcode_e    opc;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       use_rs1;
  logic       use_rs2;
  logic       use_rd;

  assign opc    = opcode_e'(inst_i[6:0]);
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];

  always_comb begin
    alu_op_o  = ALU_NONE;
    mem_op_o  = MEM_NONE;
    exc_op_o  = EXC_NONE;
    pc_op_o   = PC_INC4;
    imm_fmt_o = IMM_NONE;
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    use_rd    = 1'b0;
    case (opc)
      OPC_LUI, OPC_AUIPC: begin
        alu_op_o  = ALU_ADD;
        exc_op_o  = (opc == OPC_LUI) ? EXC_LUI : EXC_AUIPC;
        imm_fmt_o = IMM_U;
        use_rd    = 1'b1;
      end
      OPC_JAL: begin
        alu_op_o  = ALU_ADD;
        exc_op_o  = EXC_JAL;
        pc_op_o   = PC_JAL;
        imm_fmt_o = IMM_J;
        use_rd    = 1'b1;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) begin
          alu_op_o = ALU_ADD;
        end
        exc_op_o  = EXC_JALR;
        pc_op_o   = PC_JALR;
        imm_fmt_o = IMM_I;
        use_rs1   = 1'b1;
        use_rd    = 1'b1;
      end
      OPC_BRANCH: begin
        case (funct3)
          3'b000:  alu_op_o = ALU_BEQ;
          3'b001:  alu_op_o = ALU_BNE;
          3'b100:  alu_op_o = ALU_BLT;
          3'b101:  alu_op_o = ALU_BGE;
          3'b110:  alu_op_o = ALU_BLTU;
          3'b111:  alu_op_o = ALU_BGEU;
          default: alu_op_o = ALU_NONE;
        endcase
        exc_op_o  = EXC_BRANCH;
        pc_op_o   = PC_BRANCH;
        imm_fmt_o = IMM_B;
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
      end
      OPC_LOAD: begin
        case (funct3)
          3'b000:  mem_op_o = MEM_LB;
          3'b001:  mem_op_o = MEM_LH;
          3'b010:  mem_op_o = MEM_LW;
          3'b011:  mem_op_o = MEM_LD;
          3'b100:  mem_op_o = MEM_LBU;
          3'b101:  mem_op_o = MEM_LHU;
          3'b110:  mem_op_o = MEM_LWU;
          default: mem_op_o = MEM_NONE;
        endcase
        // address add only for a valid width
        alu_op_o  = (mem_op_o != MEM_NONE) ? ALU_ADD : ALU_NONE;
        exc_op_o  = EXC_LOAD;
        imm_fmt_o = IMM_I;
        use_rs1   = 1'b1;
        use_rd    = 1'b1;
      end
      OPC_STORE: begin
        case (funct3)
          3'b000:  mem_op_o = MEM_SB;
          3'b001:  mem_op_o = MEM_SH;
          3'b010:  mem_op_o = MEM_SW;
          3'b011:  mem_op_o = MEM_SD;
          default: mem_op_o = MEM_NONE;
        endcase
        alu_op_o  = (mem_op_o != MEM_NONE) ? ALU_ADD : ALU_NONE;
        exc_op_o  = EXC_STORE;
        imm_fmt_o = IMM_S;
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
      end
      OPC_OP_IMM: begin
        case (funct3)
          3'b000: alu_op_o = ALU_ADD;
          3'b010: alu_op_o = ALU_SLT;
          3'b011: alu_op_o = ALU_SLTU;
          3'b100: alu_op_o = ALU_XOR;
          3'b110: alu_op_o = ALU_OR;
          3'b111: alu_op_o = ALU_AND;
          // funct7[0] is shamt bit 5 in rv64
          3'b001: alu_op_o = (funct7[6:1] == 6'b000000) ? ALU_SLL : ALU_NONE;
          default: begin
            if (funct7[6:1] == 6'b000000) begin
              alu_op_o = ALU_SRL;
            end else if (funct7[6:1] == 6'b010000) begin
              alu_op_o = ALU_SRA;
            end
          end
        endcase
        exc_op_o  = EXC_OPIMM;
        imm_fmt_o = IMM_I;
        use_rs1   = 1'b1;
        use_rd    = 1'b1;
      end
      OPC_OP_IMM_32: begin
        casez ({funct7, funct3})
          10'b???????_000: alu_op_o = ALU_ADD;
          10'b0000000_001: alu_op_o = ALU_SLLW;
          10'b0000000_101: alu_op_o = ALU_SRLW;
          10'b0100000_101: alu_op_o = ALU_SRAW;
          default:         alu_op_o = ALU_NONE;
        endcase
        exc_op_o  = EXC_OPIMM32;
        imm_fmt_o = IMM_I;
        use_rs1   = 1'b1;
        use_rd    = 1'b1;
      end
      OPC_OP, OPC_OP_32: begin
        case ({opc == OPC_OP_32, funct7, funct3})
          11'b0_0000000_000, 11'b1_0000000_000: alu_op_o = ALU_ADD;
          11'b0_0100000_000, 11'b1_0100000_000: alu_op_o = ALU_SUB;
          11'b0_0000000_001: alu_op_o = ALU_SLL;
          11'b0_0000000_010: alu_op_o = ALU_SLT;
          11'b0_0000000_011: alu_op_o = ALU_SLTU;
          11'b0_0000000_100: alu_op_o = ALU_XOR;
          11'b0_0000000_101: alu_op_o = ALU_SRL;
          11'b0_0100000_101: alu_op_o = ALU_SRA;
          11'b0_0000000_110: alu_op_o = ALU_OR;
          11'b0_0000000_111: alu_op_o = ALU_AND;
          11'b1_0000000_001: alu_op_o = ALU_SLLW;
          11'b1_0000000_101: alu_op_o = ALU_SRLW;
          11'b1_0100000_101: alu_op_o = ALU_SRAW;
          default:           alu_op_o = ALU_NONE;
        endcase
        exc_op_o = (opc == OPC_OP_32) ? EXC_OP32 : EXC_OP;
        use_rs1  = 1'b1;
        use_rs2  = 1'b1;
        use_rd   = 1'b1;
      end
      default: begin
        alu_op_o = ALU_NONE;
      end
    endcase
    // no alu op marks an illegal encoding
    if (alu_op_o == ALU_NONE) begin
      mem_op_o  = MEM_NONE;
      exc_op_o  = EXC_NONE;
      pc_op_o   = PC_INC4;
      imm_fmt_o = IMM_NONE;
      use_rs1   = 1'b0;
      use_rs2   = 1'b0;
      use_rd    = 1'b0;
    end
  end

  assign rs1_idx_o = use_rs1 ? inst_i[19:15] : '0;
  assign rs2_idx_o = use_rs2 ? inst_i[24:20] : '0;
  assign rd_idx_o  = use_rd ? inst_i[11:7] : '0;

endmodule

// File: id_stage.f
+incdir+.
rv_isa_pkg.sv
id_uop_pkg.sv
id_inst_dec.sv
id_imm_gen.sv
id_bypass.sv
id_ctrl.sv
id_stage.sv
tb_clk_gen.sv
id_stage_tb.sv

// File: id_stage.sv
`timescale 1ns/1ns

module id_stage
  import rv_isa_pkg::*;
  import id_uop_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  // fetch side
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  xlen_t    in_pc_i,
  input  inst_t    in_inst_i,
  // register file and forwarding sources
  input  xlen_t    rs1_rdata_i,
  input  xlen_t    rs2_rdata_i,
  input  reg_idx_t ex_rd_idx_i,
  input  xlen_t    ex_rd_data_i,
  input  exc_op_e  ex_exc_op_i,
  input  reg_idx_t mem_rd_idx_i,
  input  xlen_t    mem_rd_data_i,
  // execute side
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output xlen_t    out_pc_o,
  output reg_idx_t out_rs1_idx_o,
  output reg_idx_t out_rs2_idx_o,
  output reg_idx_t out_rd_idx_o,
  output xlen_t    out_rs1_data_o,
  output xlen_t    out_rs2_data_o,
  output xlen_t    out_imm_o,
  output alu_op_e  out_alu_op_o,
  output mem_op_e  out_mem_op_o,
  output exc_op_e  out_exc_op_o,
  output pc_op_e   out_pc_op_o,
  // same-cycle register file read address
  output reg_idx_t comb_rs1_idx_o,
  output reg_idx_t comb_rs2_idx_o
);

  reg_idx_t dec_rd_idx;
  alu_op_e  dec_alu_op;
  mem_op_e  dec_mem_op;
  exc_op_e  dec_exc_op;
  pc_op_e   dec_pc_op;
  imm_fmt_e dec_imm_fmt;
  xlen_t    imm;
  xlen_t    rs1_data;
  xlen_t    rs2_data;
  logic     ex_hit;

  id_inst_dec u_inst_dec (
    .inst_i    (in_inst_i),
    .rs1_idx_o (comb_rs1_idx_o),
    .rs2_idx_o (comb_rs2_idx_o),
    .rd_idx_o  (dec_rd_idx),
    .alu_op_o  (dec_alu_op),
    .mem_op_o  (dec_mem_op),
    .exc_op_o  (dec_exc_op),
    .pc_op_o   (dec_pc_op),
    .imm_fmt_o (dec_imm_fmt)
  );

  id_imm_gen u_imm_gen (
    .inst_i (in_inst_i),
    .fmt_i  (dec_imm_fmt),
    .imm_o  (imm)
  );

  id_bypass u_bypass (
    .rs1_idx_i     (comb_rs1_idx_o),
    .rs2_idx_i     (comb_rs2_idx_o),
    .rs1_rdata_i   (rs1_rdata_i),
    .rs2_rdata_i   (rs2_rdata_i),
    .ex_rd_idx_i   (ex_rd_idx_i),
    .ex_rd_data_i  (ex_rd_data_i),
    .mem_rd_idx_i  (mem_rd_idx_i),
    .mem_rd_data_i (mem_rd_data_i),
    .rs1_data_o    (rs1_data),
    .rs2_data_o    (rs2_data),
    .ex_hit_o      (ex_hit)
  );

  id_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .in_valid_i     (in_valid_i),
    .in_ready_o     (in_ready_o),
    .out_ready_i    (out_ready_i),
    .out_valid_o    (out_valid_o),
    .ex_exc_op_i    (ex_exc_op_i),
    .ex_hit_i       (ex_hit),
    .in_pc_i        (in_pc_i),
    .rs1_idx_i      (comb_rs1_idx_o),
    .rs2_idx_i      (comb_rs2_idx_o),
    .rd_idx_i       (dec_rd_idx),
    .rs1_data_i     (rs1_data),
    .rs2_data_i     (rs2_data),
    .imm_i          (imm),
    .alu_op_i       (dec_alu_op),
    .mem_op_i       (dec_mem_op),
    .exc_op_i       (dec_exc_op),
    .pc_op_i        (dec_pc_op),
    .out_pc_o       (out_pc_o),
    .out_rs1_idx_o  (out_rs1_idx_o),
    .out_rs2_idx_o  (out_rs2_idx_o),
    .out_rd_idx_o   (out_rd_idx_o),
    .out_rs1_data_o (out_rs1_data_o),
    .out_rs2_data_o (out_rs2_data_o),
    .out_imm_o      (out_imm_o),
    .out_alu_op_o   (out_alu_op_o),
    .out_mem_op_o   (out_mem_op_o),
    .out_exc_op_o   (out_exc_op_o),
    .out_pc_op_o    (out_pc_op_o)
  );

endmodule

// File: id_stage_tb.sv
`timescale 1ns/1ns

module id_stage_tb
  import rv_isa_pkg::*;
  import id_uop_pkg::*;
();

  localparam int NUM_TXN        = 400;
  localparam int TIMEOUT_CYCLES = 16 + NUM_TXN * 8;

  typedef struct packed {
    alu_op_e alu;
    mem_op_e mem;
    exc_op_e exc;
    pc_op_e  pc_op;
  } uops_t;

  typedef struct packed {
    int       id;
    int       kind;
    xlen_t    pc;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    xlen_t    imm;
    uops_t    uops;
    logic     ex_hit;
  } exp_t;

  logic     clk_i;
  logic     rst_n_i;
  logic     in_valid_i;
  logic     in_ready_o;
  xlen_t    in_pc_i;
  inst_t    in_inst_i;
  xlen_t    rs1_rdata_i;
  xlen_t    rs2_rdata_i;
  reg_idx_t ex_rd_idx_i;
  xlen_t    ex_rd_data_i;
  exc_op_e  ex_exc_op_i;
  reg_idx_t mem_rd_idx_i;
  xlen_t    mem_rd_data_i;
  logic     out_valid_o;
  logic     out_ready_i;
  xlen_t    out_pc_o;
  reg_idx_t out_rs1_idx_o;
  reg_idx_t out_rs2_idx_o;
  reg_idx_t out_rd_idx_o;
  xlen_t    out_rs1_data_o;
  xlen_t    out_rs2_data_o;
  xlen_t    out_imm_o;
  alu_op_e  out_alu_op_o;
  mem_op_e  out_mem_op_o;
  exc_op_e  out_exc_op_o;
  pc_op_e   out_pc_op_o;
  reg_idx_t comb_rs1_idx_o;
  reg_idx_t comb_rs2_idx_o;

  exp_t exp_q[$];
  int   n_acc = 0;
  int   n_done = 0;
  int   n_hold = 0;
  int   n_bp = 0;
  int   cycles = 0;
  int   cur_kind;
  logic take_now = 1'b0;
  logic load_use_now = 1'b0;

  tb_clk_gen u_clk_gen (
    .clk_o   (clk_i),
    .rst_n_o (rst_n_i)
  );

  id_stage id_stage_i (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .in_valid_i     (in_valid_i),
    .in_ready_o     (in_ready_o),
    .in_pc_i        (in_pc_i),
    .in_inst_i      (in_inst_i),
    .rs1_rdata_i    (rs1_rdata_i),
    .rs2_rdata_i    (rs2_rdata_i),
    .ex_rd_idx_i    (ex_rd_idx_i),
    .ex_rd_data_i   (ex_rd_data_i),
    .ex_exc_op_i    (ex_exc_op_i),
    .mem_rd_idx_i   (mem_rd_idx_i),
    .mem_rd_data_i  (mem_rd_data_i),
    .out_valid_o    (out_valid_o),
    .out_ready_i    (out_ready_i),
    .out_pc_o       (out_pc_o),
    .out_rs1_idx_o  (out_rs1_idx_o),
    .out_rs2_idx_o  (out_rs2_idx_o),
    .out_rd_idx_o   (out_rd_idx_o),
    .out_rs1_data_o (out_rs1_data_o),
    .out_rs2_data_o (out_rs2_data_o),
    .out_imm_o      (out_imm_o),
    .out_alu_op_o   (out_alu_op_o),
    .out_mem_op_o   (out_mem_op_o),
    .out_exc_op_o   (out_exc_op_o),
    .out_pc_op_o    (out_pc_op_o),
    .comb_rs1_idx_o (comb_rs1_idx_o),
    .comb_rs2_idx_o (comb_rs2_idx_o)
  );

  // register file model, x0 reads zero
  function automatic xlen_t rf_value(input reg_idx_t idx);
    xlen_t val;
    if (idx == 5'd0) begin
      val = '0;
    end else begin
      val = {8{3'b011, idx}} ^ 64'h5a3c_0f96_c3a5_690f;
    end
    return val;
  endfunction

  always_comb begin
    rs1_rdata_i = rf_value(comb_rs1_idx_o);
    rs2_rdata_i = rf_value(comb_rs2_idx_o);
  end

  function automatic string kind_name(input int kind);
    case (kind)
      0:       return "arith";
      1:       return "memctl";
      default: return "illegal";
    endcase
  endfunction

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input xlen_t expected, input xlen_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("CHECK FAILED: %s expected %h actual %h",
                                  name, expected, actual));
    end
  endtask

  task automatic check_idx(input string name, input reg_idx_t expected, input reg_idx_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("CHECK FAILED: %s expected %0d actual %0d",
                                  name, expected, actual));
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("CHECK FAILED: %s expected %0b actual %0b",
                                  name, expected, actual));
    end
  endtask

  task automatic check_uop(input string name, input uops_t expected, input uops_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("CHECK FAILED: %s expected %s/%s/%s/%s actual %s/%s/%s/%s",
        name, expected.alu.name(), expected.mem.name(), expected.exc.name(),
        expected.pc_op.name(), actual.alu.name(), actual.mem.name(), actual.exc.name(),
        actual.pc_op.name()));
    end
  endtask

  // field given left aligned in a 32-bit word, width counts its bits
  function automatic xlen_t sign_extend(input logic [31:0] top, input int width);
    logic signed [63:0] wide;
    wide = {top, 32'b0};
    return wide >>> (64 - width);
  endfunction

  // later match wins, so ex overrides mem
  function automatic xlen_t pick_operand(input reg_idx_t idx, input reg_idx_t ex_idx,
                                         input xlen_t ex_data, input reg_idx_t mem_idx,
                                         input xlen_t mem_data);
    xlen_t val;
    val = rf_value(idx);
    if (idx != 5'd0 && idx == mem_idx) begin
      val = mem_data;
    end
    if (idx != 5'd0 && idx == ex_idx) begin
      val = ex_data;
    end
    return val;
  endfunction

  function automatic exp_t ref_decode(input inst_t inst, input xlen_t pc,
                                      input reg_idx_t ex_idx, input xlen_t ex_data,
                                      input reg_idx_t mem_idx, input xlen_t mem_data);
    exp_t       e;
    logic [2:0] f3;
    logic [6:0] f7;
    imm_fmt_e   fmt;
    logic       u1;
    logic       u2;
    logic       ud;
    e    = '0;
    f3   = inst[14:12];
    f7   = inst[31:25];
    fmt  = IMM_NONE;
    u1   = 1'b0;
    u2   = 1'b0;
    ud   = 1'b0;
    e.pc = pc;
    case (inst[6:0])
      OPC_LUI, OPC_AUIPC: begin
        e.uops.alu = ALU_ADD;
        e.uops.exc = (inst[6:0] == OPC_LUI) ? EXC_LUI : EXC_AUIPC;
        fmt = IMM_U;
        ud  = 1'b1;
      end
      OPC_JAL: begin
        e.uops.alu   = ALU_ADD;
        e.uops.exc   = EXC_JAL;
        e.uops.pc_op = PC_JAL;
        fmt = IMM_J;
        ud  = 1'b1;
      end
      OPC_JALR: begin
        e.uops.alu   = (f3 == 3'd0) ? ALU_ADD : ALU_NONE;
        e.uops.exc   = EXC_JALR;
        e.uops.pc_op = PC_JALR;
        fmt = IMM_I;
        u1  = 1'b1;
        ud  = 1'b1;
      end
      OPC_BRANCH: begin
        case (f3)
          3'd0: e.uops.alu = ALU_BEQ;
          3'd1: e.uops.alu = ALU_BNE;
          3'd4: e.uops.alu = ALU_BLT;
          3'd5: e.uops.alu = ALU_BGE;
          3'd6: e.uops.alu = ALU_BLTU;
          3'd7: e.uops.alu = ALU_BGEU;
          default: e.uops.alu = ALU_NONE;
        endcase
        e.uops.exc   = EXC_BRANCH;
        e.uops.pc_op = PC_BRANCH;
        fmt = IMM_B;
        u1  = 1'b1;
        u2  = 1'b1;
      end
      OPC_LOAD: begin
        case (f3)
          3'd0: e.uops.mem = MEM_LB;
          3'd1: e.uops.mem = MEM_LH;
          3'd2: e.uops.mem = MEM_LW;
          3'd3: e.uops.mem = MEM_LD;
          3'd4: e.uops.mem = MEM_LBU;
          3'd5: e.uops.mem = MEM_LHU;
          3'd6: e.uops.mem = MEM_LWU;
          default: e.uops.mem = MEM_NONE;
        endcase
        e.uops.alu = (f3 != 3'd7) ? ALU_ADD : ALU_NONE;
        e.uops.exc = EXC_LOAD;
        fmt = IMM_I;
        u1  = 1'b1;
        ud  = 1'b1;
      end
      OPC_STORE: begin
        case (f3)
          3'd0: e.uops.mem = MEM_SB;
          3'd1: e.uops.mem = MEM_SH;
          3'd2: e.uops.mem = MEM_SW;
          3'd3: e.uops.mem = MEM_SD;
          default: e.uops.mem = MEM_NONE;
        endcase
        e.uops.alu = (f3[2] == 1'b0) ? ALU_ADD : ALU_NONE;
        e.uops.exc = EXC_STORE;
        fmt = IMM_S;
        u1  = 1'b1;
        u2  = 1'b1;
      end
      OPC_OP_IMM: begin
        case (f3)
          3'd0: e.uops.alu = ALU_ADD;
          3'd2: e.uops.alu = ALU_SLT;
          3'd3: e.uops.alu = ALU_SLTU;
          3'd4: e.uops.alu = ALU_XOR;
          3'd6: e.uops.alu = ALU_OR;
          3'd7: e.uops.alu = ALU_AND;
          3'd1: e.uops.alu = (f7[6:1] == 6'h00) ? ALU_SLL : ALU_NONE;
          default: begin
            if (f7[6:1] == 6'h00) begin
              e.uops.alu = ALU_SRL;
            end else if (f7[6:1] == 6'h10) begin
              e.uops.alu = ALU_SRA;
            end
          end
        endcase
        e.uops.exc = EXC_OPIMM;
        fmt = IMM_I;
        u1  = 1'b1;
        ud  = 1'b1;
      end
      OPC_OP_IMM_32: begin
        case ({f7, f3})
          {7'h00, 3'd1}: e.uops.alu = ALU_SLLW;
          {7'h00, 3'd5}: e.uops.alu = ALU_SRLW;
          {7'h20, 3'd5}: e.uops.alu = ALU_SRAW;
          default: e.uops.alu = (f3 == 3'd0) ? ALU_ADD : ALU_NONE;
        endcase
        e.uops.exc = EXC_OPIMM32;
        fmt = IMM_I;
        u1  = 1'b1;
        ud  = 1'b1;
      end
      OPC_OP: begin
        case ({f7, f3})
          {7'h00, 3'd0}: e.uops.alu = ALU_ADD;
          {7'h20, 3'd0}: e.uops.alu = ALU_SUB;
          {7'h00, 3'd1}: e.uops.alu = ALU_SLL;
          {7'h00, 3'd2}: e.uops.alu = ALU_SLT;
          {7'h00, 3'd3}: e.uops.alu = ALU_SLTU;
          {7'h00, 3'd4}: e.uops.alu = ALU_XOR;
          {7'h00, 3'd5}: e.uops.alu = ALU_SRL;
          {7'h20, 3'd5}: e.uops.alu = ALU_SRA;
          {7'h00, 3'd6}: e.uops.alu = ALU_OR;
          {7'h00, 3'd7}: e.uops.alu = ALU_AND;
          default: e.uops.alu = ALU_NONE;
        endcase
        e.uops.exc = EXC_OP;
        u1 = 1'b1;
        u2 = 1'b1;
        ud = 1'b1;
      end
      OPC_OP_32: begin
        case ({f7, f3})
          {7'h00, 3'd0}: e.uops.alu = ALU_ADD;
          {7'h20, 3'd0}: e.uops.alu = ALU_SUB;
          {7'h00, 3'd1}: e.uops.alu = ALU_SLLW;
          {7'h00, 3'd5}: e.uops.alu = ALU_SRLW;
          {7'h20, 3'd5}: e.uops.alu = ALU_SRAW;
          default: e.uops.alu = ALU_NONE;
        endcase
        e.uops.exc = EXC_OP32;
        u1 = 1'b1;
        u2 = 1'b1;
        ud = 1'b1;
      end
      default: begin
        e.uops.alu = ALU_NONE;
      end
    endcase
    // illegal: no micro-ops, inc4, no indices, no immediate
    if (e.uops.alu == ALU_NONE) begin
      e.uops = '{ALU_NONE, MEM_NONE, EXC_NONE, PC_INC4};
      fmt = IMM_NONE;
      u1  = 1'b0;
      u2  = 1'b0;
      ud  = 1'b0;
    end
    e.rs1 = u1 ? inst[19:15] : 5'd0;
    e.rs2 = u2 ? inst[24:20] : 5'd0;
    e.rd  = ud ? inst[11:7] : 5'd0;
    case (fmt)
      IMM_I: e.imm = sign_extend({inst[31:20], 20'b0}, 12);
      IMM_S: e.imm = sign_extend({inst[31:25], inst[11:7], 20'b0}, 12);
      IMM_B: e.imm = sign_extend({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0, 19'b0}, 13);
      IMM_U: e.imm = sign_extend({inst[31:12], 12'b0}, 32);
      IMM_J: e.imm = sign_extend({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0, 11'b0}, 21);
      default: e.imm = '0;
    endcase
    e.rs1_data = pick_operand(e.rs1, ex_idx, ex_data, mem_idx, mem_data);
    e.rs2_data = pick_operand(e.rs2, ex_idx, ex_data, mem_idx, mem_data);
    e.ex_hit   = (e.rs1 != 5'd0 && e.rs1 == ex_idx) || (e.rs2 != 5'd0 && e.rs2 == ex_idx);
    return e;
  endfunction

  function automatic inst_t make_inst(input int kind);
    inst_t w;
    w = $urandom();
    case (kind)
      0: begin
        case ($urandom_range(0, 3))
          0: w[6:0] = OPC_OP;
          1: w[6:0] = OPC_OP_32;
          2: w[6:0] = OPC_OP_IMM;
          default: w[6:0] = OPC_OP_IMM_32;
        endcase
        // funct7 01 is a shamt bit in op-imm and mul in op
        case ($urandom_range(0, 3))
          0: w[31:25] = 7'h00;
          1: w[31:25] = 7'h20;
          2: w[31:25] = 7'h01;
          default: ;
        endcase
        if ($urandom_range(0, 7) == 0) begin
          w[19:15] = 5'd0;
        end
      end
      1: begin
        case ($urandom_range(0, 6))
          0: w[6:0] = OPC_LOAD;
          1: w[6:0] = OPC_STORE;
          2: w[6:0] = OPC_BRANCH;
          3: w[6:0] = OPC_JAL;
          4: w[6:0] = OPC_JALR;
          5: w[6:0] = OPC_LUI;
          default: w[6:0] = OPC_AUIPC;
        endcase
      end
      default: begin
        case ($urandom_range(0, 3))
          0: begin
            w[6:0]   = OPC_OP;
            w[31:25] = 7'h01;
          end
          1: w[6:0] = 7'h73;
          2: w[6:0] = 7'h0f;
          default: ;
        endcase
      end
    endcase
    return w;
  endfunction

  // mostly collide with a source field or x0
  function automatic reg_idx_t pick_fwd_idx(input inst_t inst);
    reg_idx_t idx;
    case ($urandom_range(0, 3))
      0: idx = inst[19:15];
      1: idx = inst[24:20];
      2: idx = 5'd0;
      default: idx = reg_idx_t'($urandom_range(0, 31));
    endcase
    return idx;
  endfunction

  function automatic exc_op_e pick_ex_class();
    exc_op_e cls;
    case ($urandom_range(0, 3))
      0: cls = EXC_NONE;
      1: cls = EXC_OP;
      2: cls = EXC_STORE;
      default: cls = EXC_OPIMM;
    endcase
    return cls;
  endfunction

  task automatic drive_side_inputs(input inst_t inst);
    ex_rd_idx_i   <= pick_fwd_idx(inst);
    mem_rd_idx_i  <= pick_fwd_idx(inst);
    ex_rd_data_i  <= {$urandom(), $urandom()};
    mem_rd_data_i <= {$urandom(), $urandom()};
    // the load in ex moves on after one hold cycle
    if (load_use_now || $urandom_range(0, 2) != 0) begin
      ex_exc_op_i <= pick_ex_class();
    end else begin
      ex_exc_op_i <= EXC_LOAD;
    end
  endtask

  task automatic compare_outputs(input exp_t e);
    string tag;
    uops_t act;
    tag       = $sformatf("%s #%0d", kind_name(e.kind), e.id);
    act.alu   = out_alu_op_o;
    act.mem   = out_mem_op_o;
    act.exc   = out_exc_op_o;
    act.pc_op = out_pc_op_o;
    check_word({tag, " pc"}, e.pc, out_pc_o);
    check_idx({tag, " rs1 idx"}, e.rs1, out_rs1_idx_o);
    check_idx({tag, " rs2 idx"}, e.rs2, out_rs2_idx_o);
    check_idx({tag, " rd idx"}, e.rd, out_rd_idx_o);
    check_word({tag, " rs1 data"}, e.rs1_data, out_rs1_data_o);
    check_word({tag, " rs2 data"}, e.rs2_data, out_rs2_data_o);
    check_word({tag, " imm"}, e.imm, out_imm_o);
    check_uop({tag, " uops"}, e.uops, act);
  endtask

  // compare process, samples mid-cycle when everything has settled
  always @(negedge clk_i) begin
    exp_t e;
    logic hazard;
    logic ready_exp;
    if (rst_n_i) begin
      e = ref_decode(in_inst_i, in_pc_i, ex_rd_idx_i, ex_rd_data_i,
                     mem_rd_idx_i, mem_rd_data_i);
      hazard    = (ex_exc_op_i == EXC_LOAD) && e.ex_hit;
      ready_exp = ((exp_q.size() == 0) || out_ready_i) && !hazard;
      check_flag("out_valid", exp_q.size() != 0, out_valid_o);
      check_flag("in_ready", ready_exp, in_ready_o);
      if (in_valid_i) begin
        check_idx("comb rs1 idx", e.rs1, comb_rs1_idx_o);
        check_idx("comb rs2 idx", e.rs2, comb_rs2_idx_o);
      end
      // held item must match the queue head every cycle it waits
      if (out_valid_o) begin
        compare_outputs(exp_q[0]);
        if (out_ready_i) begin
          void'(exp_q.pop_front());
          n_done++;
        end else begin
          n_bp++;
        end
      end
      take_now     = in_valid_i && in_ready_o;
      load_use_now = in_valid_i && hazard;
      if (load_use_now) begin
        n_hold++;
      end
      if (take_now) begin
        e.id   = n_acc;
        e.kind = cur_kind;
        exp_q.push_back(e);
        n_acc++;
      end
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      stop_with_failure($sformatf("timeout after %0d cycles with %0d of %0d transfers done",
                                  cycles, n_done, NUM_TXN));
    end
  end

  initial begin
    inst_t next_inst;
    int    kind;
    void'($urandom(48949));
    in_valid_i    <= 1'b0;
    in_pc_i       <= 64'h0000_0000_8000_0000;
    in_inst_i     <= '0;
    ex_rd_idx_i   <= '0;
    ex_rd_data_i  <= '0;
    ex_exc_op_i   <= EXC_NONE;
    mem_rd_idx_i  <= '0;
    mem_rd_data_i <= '0;
    out_ready_i   <= 1'b0;
    cur_kind      <= 0;
    wait (rst_n_i == 1'b1);
    while (n_done < NUM_TXN) begin
      @(posedge clk_i);
      next_inst = in_inst_i;
      out_ready_i <= ($urandom_range(0, 1) == 1);
      // fetch keeps an offered instruction until it is taken
      if (!in_valid_i || take_now) begin
        if (n_acc < NUM_TXN && $urandom_range(0, 7) != 0) begin
          kind      = ($urandom_range(0, 9) < 4) ? 0 : 1;
          kind      = ($urandom_range(0, 4) == 0) ? 2 : kind;
          next_inst = make_inst(kind);
          cur_kind   <= kind;
          in_inst_i  <= next_inst;
          in_pc_i    <= in_pc_i + 64'd4;
          in_valid_i <= 1'b1;
        end else begin
          in_valid_i <= 1'b0;
        end
      end
      drive_side_inputs(next_inst);
    end
    repeat (2) @(posedge clk_i);
    if (exp_q.size() != 0 || n_acc != NUM_TXN) begin
      stop_with_failure("expected results left in the queue at the end of the run");
    end else if (n_hold == 0) begin
      stop_with_failure("no load-use hold happened during the run");
    end else if (n_bp == 0) begin
      stop_with_failure("no back-pressure cycle happened during the run");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

// File: id_uop_pkg.sv
package id_uop_pkg;

  // alu operation for execute
  typedef enum logic [4:0] {
    ALU_NONE,
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLLW,
    ALU_SRLW,
    ALU_SRAW,
    ALU_SLT,
    ALU_SLTU,
    ALU_BEQ,
    ALU_BNE,
    ALU_BLT,
    ALU_BGE,
    ALU_BLTU,
    ALU_BGEU
  } alu_op_e;

  // memory access kind
  typedef enum logic [3:0] {
    MEM_NONE, MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW,
    MEM_LWU, MEM_LD, MEM_SB, MEM_SH, MEM_SW, MEM_SD
  } mem_op_e;

  // execute class, one per major opcode
  typedef enum logic [3:0] {
    EXC_NONE, EXC_AUIPC, EXC_LUI, EXC_JAL, EXC_JALR, EXC_LOAD,
    EXC_STORE, EXC_BRANCH, EXC_OPIMM, EXC_OPIMM32, EXC_OP, EXC_OP32
  } exc_op_e;

  // next pc selection
  typedef enum logic [1:0] {
    PC_INC4, PC_BRANCH, PC_JAL, PC_JALR
  } pc_op_e;

  // immediate layout in the instruction word
  typedef enum logic [2:0] {
    IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
  } imm_fmt_e;

endpackage

// File: rv_isa_pkg.sv
`include "rv_macros.svh"

package rv_isa_pkg;

  // major opcodes kept by this decoder
  typedef enum logic [6:0] {
    OPC_LOAD      = 7'b0000011,
    OPC_STORE     = 7'b0100011,
    OPC_BRANCH    = 7'b1100011,
    OPC_JALR      = 7'b1100111,
    OPC_JAL       = 7'b1101111,
    OPC_OP_IMM    = 7'b0010011,
    OPC_OP        = 7'b0110011,
    OPC_AUIPC     = 7'b0010111,
    OPC_LUI       = 7'b0110111,
    OPC_OP_IMM_32 = 7'b0011011,
    OPC_OP_32     = 7'b0111011
  } opcode_e;

  // one data word
  typedef logic [`RV_XLEN-1:0] xlen_t;

  // gpr index
  typedef logic [`RV_REG_W-1:0] reg_idx_t;

  // raw instruction from fetch
  typedef logic [`RV_INST_W-1:0] inst_t;

endpackage

// File: rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// base ISA widths, fixed by RV64I

// data path width
`define RV_XLEN 64

// instruction word width
`define RV_INST_W 32

// register file index width
`define RV_REG_W 5

// immediate width after sign extension
`define RV_IMM_W 64

`endif

// File: tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // reset held low for 16 cycles
  initial begin
    rst_n_o <= 1'b0;
    repeat (16) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule
